/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := mips_core_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input  wire logic                clk,
	input  wire logic                arst_n,
	output mips_pkg::word_t          imem_addr,
	input  wire mips_pkg::word_t     imem_data,
	output logic                     wb_en,
	output mips_pkg::reg_addr_t      wb_addr,
	output mips_pkg::word_t          wb_data
);

	// Fetch to decode
	mips_pkg::word_t pc_d, instr_d;

	// Branch redirect from execute
	logic            branch_taken;
	mips_pkg::word_t branch_target;

	// Decode to execute
	mips_pkg::reg_addr_t rs_x, rt_x, dest_x;
	mips_pkg::word_t     rd1_x, rd2_x, imm_x, pc_plus4_x;
	mips_pkg::alu_op_e   alu_op_x;
	logic reg_write_x, mem_read_x, mem_write_x, alu_src_x, is_branch_x;

	// Execute to memory, also the memory-stage forwarding tap
	mips_pkg::word_t     alu_result_m, store_data_m;
	mips_pkg::reg_addr_t dest_m;
	logic reg_write_m, mem_read_m, mem_write_m;

	// --------------------------------------------------
	// Stages
	// --------------------------------------------------
	mips_fetch u_fetch (
		.clk, .arst_n,
		.branch_taken, .branch_target,
		.imem_data, .imem_addr,
		.pc_d, .instr_d
	);

	mips_decode u_decode (
		.clk, .arst_n,
		.pc_d, .instr_d,
		.flush(branch_taken),
		.wb_en, .wb_addr, .wb_data,
		.rs_x, .rt_x, .dest_x, .rd1_x, .rd2_x, .imm_x, .pc_plus4_x, .alu_op_x,
		.reg_write_x, .mem_read_x, .mem_write_x, .alu_src_x, .is_branch_x
	);

	mips_execute u_execute (
		.clk, .arst_n,
		.rs_x, .rt_x, .dest_x, .rd1_x, .rd2_x, .imm_x, .pc_plus4_x, .alu_op_x,
		.reg_write_x, .mem_read_x, .mem_write_x, .alu_src_x, .is_branch_x,
		.fwd_m_addr(dest_m), .fwd_m_en(reg_write_m), .fwd_m_data(alu_result_m),
		.wb_en, .wb_addr, .wb_data,
		.branch_taken, .branch_target,
		.alu_result_m, .store_data_m, .dest_m,
		.reg_write_m, .mem_read_m, .mem_write_m
	);

	mips_memory u_memory (
		.clk, .arst_n,
		.alu_result_m, .store_data_m, .dest_m,
		.reg_write_m, .mem_read_m, .mem_write_m,
		.wb_en, .wb_addr, .wb_data
	);

endmodule

`default_nettype wire

/* hw/mips_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire mips_pkg::word_t     pc_d,
	input  wire mips_pkg::word_t     instr_d,
	input  wire logic                flush,
	input  wire logic                wb_en,
	input  wire mips_pkg::reg_addr_t wb_addr,
	input  wire mips_pkg::word_t     wb_data,
	output mips_pkg::reg_addr_t      rs_x,
	output mips_pkg::reg_addr_t      rt_x,
	output mips_pkg::reg_addr_t      dest_x,
	output mips_pkg::word_t          rd1_x,
	output mips_pkg::word_t          rd2_x,
	output mips_pkg::word_t          imm_x,
	output mips_pkg::word_t          pc_plus4_x,
	output mips_pkg::alu_op_e        alu_op_x,
	output logic                     reg_write_x,
	output logic                     mem_read_x,
	output logic                     mem_write_x,
	output logic                     alu_src_x,
	output logic                     is_branch_x
);

	// Instruction fields
	logic [5:0]          opcode;
	logic [5:0]          funct;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;

	assign opcode = instr_d[31:26];
	assign rs     = instr_d[25:21];
	assign rt     = instr_d[20:16];
	assign rd     = instr_d[15:11];
	assign funct  = instr_d[5:0];

	// --------------------------------------------------
	// Control decode
	// --------------------------------------------------
	mips_pkg::alu_op_e   alu_op;
	mips_pkg::reg_addr_t dest;
	logic reg_dst, reg_write, mem_read, mem_write, alu_src, is_branch;

	always_comb begin
		alu_op    = mips_pkg::ALU_ADD;
		reg_dst   = 1'b0;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		alu_src   = 1'b0;
		is_branch = 1'b0;
		case (opcode)
			mips_pkg::OPC_RTYPE: begin
				reg_dst   = 1'b1;
				reg_write = 1'b1;
				case (funct)
					mips_pkg::FN_ADD: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
					default:          reg_write = 1'b0; // nop and unsupported functs
				endcase
			end
			mips_pkg::OPC_ADDI: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
			end
			mips_pkg::OPC_LW: begin
				reg_write = 1'b1;
				mem_read  = 1'b1;
				alu_src   = 1'b1;
			end
			mips_pkg::OPC_SW: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
			end
			mips_pkg::OPC_BEQ: begin
				is_branch = 1'b1;
				alu_op    = mips_pkg::ALU_SUB;
			end
			default: ;
		endcase
	end

	assign dest = reg_dst ? rd : rt;

	// --------------------------------------------------
	// Register bank, write-first
	// --------------------------------------------------
	mips_pkg::word_t regs [mips_pkg::REG_COUNT];
	mips_pkg::word_t rd1, rd2;

	always_ff @(posedge clk) begin
		if (wb_en && wb_addr != '0)
			regs[wb_addr] <= wb_data;
	end

	assign rd1 = (rs == '0) ? '0 : (wb_en && wb_addr == rs) ? wb_data : regs[rs];
	assign rd2 = (rt == '0) ? '0 : (wb_en && wb_addr == rt) ? wb_data : regs[rt];

	// Decode to execute register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_write_x <= 1'b0;
			mem_read_x  <= 1'b0;
			mem_write_x <= 1'b0;
			alu_src_x   <= 1'b0;
			is_branch_x <= 1'b0;
		end else if (flush) begin // Bubble behind a taken beq
			reg_write_x <= 1'b0;
			mem_read_x  <= 1'b0;
			mem_write_x <= 1'b0;
			alu_src_x   <= 1'b0;
			is_branch_x <= 1'b0;
		end else begin
			reg_write_x <= reg_write && (dest != '0); // r0 writes dropped here
			mem_read_x  <= mem_read;
			mem_write_x <= mem_write;
			alu_src_x   <= alu_src;
			is_branch_x <= is_branch;
		end
	end

	always_ff @(posedge clk) begin
		rs_x       <= rs;
		rt_x       <= rt;
		dest_x     <= dest;
		rd1_x      <= rd1;
		rd2_x      <= rd2;
		imm_x      <= {{16{instr_d[15]}}, instr_d[15:0]}; // Sign extend
		pc_plus4_x <= pc_d + 32'd4;
		alu_op_x   <= alu_op;
	end

	rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_read_x && mem_write_x))
		else $error("decode issued load and store together");

endmodule

`default_nettype wire

/* hw/mips_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire mips_pkg::reg_addr_t rs_x,
	input  wire mips_pkg::reg_addr_t rt_x,
	input  wire mips_pkg::reg_addr_t dest_x,
	input  wire mips_pkg::word_t     rd1_x,
	input  wire mips_pkg::word_t     rd2_x,
	input  wire mips_pkg::word_t     imm_x,
	input  wire mips_pkg::word_t     pc_plus4_x,
	input  wire mips_pkg::alu_op_e   alu_op_x,
	input  wire logic                reg_write_x,
	input  wire logic                mem_read_x,
	input  wire logic                mem_write_x,
	input  wire logic                alu_src_x,
	input  wire logic                is_branch_x,
	input  wire mips_pkg::reg_addr_t fwd_m_addr,
	input  wire logic                fwd_m_en,
	input  wire mips_pkg::word_t     fwd_m_data,
	input  wire logic                wb_en,
	input  wire mips_pkg::reg_addr_t wb_addr,
	input  wire mips_pkg::word_t     wb_data,
	output logic                     branch_taken,
	output mips_pkg::word_t          branch_target,
	output mips_pkg::word_t          alu_result_m,
	output mips_pkg::word_t          store_data_m,
	output mips_pkg::reg_addr_t      dest_m,
	output logic                     reg_write_m,
	output logic                     mem_read_m,
	output logic                     mem_write_m
);

	// --------------------------------------------------
	// Forwarding
	// --------------------------------------------------
	// Memory stage is younger, so it wins over writeback
	function automatic mips_pkg::word_t fwd_sel(input mips_pkg::reg_addr_t idx,
	                                            input mips_pkg::word_t     reg_val);
		if (idx == '0)
			return '0;
		else if (fwd_m_en && fwd_m_addr == idx)
			return fwd_m_data;
		else if (wb_en && wb_addr == idx)
			return wb_data;
		else
			return reg_val;
	endfunction

	mips_pkg::word_t src_a;
	mips_pkg::word_t src_b;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t alu_y;
	logic            slt_bit;

	always_comb begin
		src_a = fwd_sel(rs_x, rd1_x);
		src_b = fwd_sel(rt_x, rd2_x); // Also the store data
	end

	assign alu_b = alu_src_x ? imm_x : src_b;

	// --------------------------------------------------
	// ALU
	// --------------------------------------------------
	assign slt_bit = $signed(src_a) < $signed(alu_b);

	always_comb begin
		case (alu_op_x)
			mips_pkg::ALU_ADD: alu_y = src_a + alu_b;
			mips_pkg::ALU_SUB: alu_y = src_a - alu_b;
			mips_pkg::ALU_AND: alu_y = src_a & alu_b;
			mips_pkg::ALU_OR:  alu_y = src_a | alu_b;
			mips_pkg::ALU_SLT: alu_y = {{(mips_pkg::DATA_W-1){1'b0}}, slt_bit};
			default:           alu_y = '0;
		endcase
	end

	// beq resolves here
	assign branch_taken  = is_branch_x && (src_a == src_b);
	assign branch_target = pc_plus4_x + {imm_x[29:0], 2'b00};

	// Execute to memory register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_write_m <= 1'b0;
			mem_read_m  <= 1'b0;
			mem_write_m <= 1'b0;
		end else begin
			reg_write_m <= reg_write_x;
			mem_read_m  <= mem_read_x;
			mem_write_m <= mem_write_x;
		end
	end

	always_ff @(posedge clk) begin
		alu_result_m <= alu_y;
		store_data_m <= src_b;
		dest_m       <= dest_x;
	end

endmodule

`default_nettype wire

/* hw/mips_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_fetch (
	input  wire logic           clk,
	input  wire logic           arst_n,
	input  wire logic           branch_taken,
	input  wire mips_pkg::word_t branch_target,
	input  wire mips_pkg::word_t imem_data,
	output mips_pkg::word_t     imem_addr,
	output mips_pkg::word_t     pc_d,
	output mips_pkg::word_t     instr_d
);

	mips_pkg::word_t pc;
	mips_pkg::word_t pc_next;

	assign imem_addr = pc;
	assign pc_next   = branch_taken ? branch_target : pc + 32'd4; // Redirect from execute

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= mips_pkg::RESET_PC;
			instr_d <= '0; // All zero word decodes as a nop
		end else begin
			pc      <= pc_next;
			instr_d <= branch_taken ? '0 : imem_data; // Squash wrong-path fetch
		end
	end

	always_ff @(posedge clk) begin
		pc_d <= pc;
	end

	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
		else $error("fetch PC not word aligned: %h", pc);

endmodule

`default_nettype wire

/* hw/mips_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_memory (
	input  wire logic                clk,
	input  wire logic                arst_n,
	input  wire mips_pkg::word_t     alu_result_m,
	input  wire mips_pkg::word_t     store_data_m,
	input  wire mips_pkg::reg_addr_t dest_m,
	input  wire logic                reg_write_m,
	input  wire logic                mem_read_m,
	input  wire logic                mem_write_m,
	output logic                     wb_en,
	output mips_pkg::reg_addr_t      wb_addr,
	output mips_pkg::word_t          wb_data
);

	// --------------------------------------------------
	// Data memory, word addressed
	// --------------------------------------------------
	mips_pkg::word_t dmem [mips_pkg::DMEM_DEPTH];
	logic [$clog2(mips_pkg::DMEM_DEPTH)-1:0] dmem_idx;
	mips_pkg::word_t load_data;

	assign dmem_idx = alu_result_m[$clog2(mips_pkg::DMEM_DEPTH)+1:2]; // Byte address to word

	always_ff @(posedge clk) begin
		if (mem_write_m)
			dmem[dmem_idx] <= store_data_m;
	end

	assign load_data = dmem[dmem_idx];

	// Memory to writeback register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_en <= 1'b0;
		else
			wb_en <= reg_write_m;
	end

	always_ff @(posedge clk) begin
		wb_addr <= dest_m;
		wb_data <= mem_read_m ? load_data : alu_result_m; // Writeback mux
	end

	addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_read_m || mem_write_m) |-> alu_result_m[1:0] == 2'b00)
		else $error("unaligned data access at %h", alu_result_m);

	addr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_read_m || mem_write_m) |-> alu_result_m < 4 * mips_pkg::DMEM_DEPTH)
		else $error("data access out of range at %h", alu_result_m);

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// --------------------------------------------------
	// Widths and sizes
	// --------------------------------------------------
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT  = 32;
	localparam int DMEM_DEPTH = 256; // Words

	localparam logic [DATA_W-1:0] RESET_PC = 32'h00400000;

	typedef logic [DATA_W-1:0]     word_t;     // PC, instruction, operand, result
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// ALU operation carried down the pipe
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	// --------------------------------------------------
	// Major opcodes, instr[31:26]
	// --------------------------------------------------
	localparam logic [5:0] OPC_RTYPE = 6'h00;
	localparam logic [5:0] OPC_BEQ   = 6'h04;
	localparam logic [5:0] OPC_ADDI  = 6'h08;
	localparam logic [5:0] OPC_LW    = 6'h23;
	localparam logic [5:0] OPC_SW    = 6'h2b;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

endpackage

`default_nettype wire

/* sim.f */
hw/mips_pkg.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_execute.sv
hw/mips_memory.sv
hw/mips_core.sv
verification/tb_clock_gen.sv
verification/mips_core_tb.sv

/* verification/mips_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

	localparam int              PROG_WORDS = 64;
	localparam int              WAIT_LIMIT = 50; // Cycles per awaited write
	localparam int              DRIVE_DLY  = 1;  // ns after the rising edge
	localparam logic [31:0]     SEED       = 32'hfe4adc42;
	localparam int              TAKEN_IDX  = 14; // Slot of the taken beq
	localparam int              BR_OFFSET  = 2;
	localparam mips_pkg::word_t TAKEN_PC   = mips_pkg::RESET_PC + 32'(4 * TAKEN_IDX);
	localparam mips_pkg::word_t TAKEN_TGT  = TAKEN_PC + 32'(4 * (1 + BR_OFFSET));

	logic                clk;
	logic                arst_n;
	mips_pkg::word_t     imem_addr;
	mips_pkg::word_t     imem_data;
	logic                wb_en;
	mips_pkg::reg_addr_t wb_addr;
	mips_pkg::word_t     wb_data;

	mips_pkg::word_t prog [PROG_WORDS];
	mips_pkg::word_t exp_val [mips_pkg::REG_COUNT]; // Expected value per register
	bit              may_write [mips_pkg::REG_COUNT];
	bit              seen [mips_pkg::REG_COUNT];
	mips_pkg::word_t fetch_off;
	int              cyc;
	int              errors;
	int              passed;
	int              failed;

	tb_clock_gen clk_gen (.clk);

	mips_core dut0 (.clk, .arst_n, .imem_addr, .imem_data, .wb_en, .wb_addr, .wb_data);

	// Instruction ROM, nop outside the program
	always_comb begin
		fetch_off = imem_addr - mips_pkg::RESET_PC;
		if (fetch_off < 32'(4 * PROG_WORDS))
			imem_data = prog[fetch_off[7:2]];
		else
			imem_data = '0;
	end

	// --------------------------------------------------
	// Encoding and reference arithmetic
	// --------------------------------------------------
	function automatic mips_pkg::word_t sext(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic mips_pkg::word_t slt_val(input mips_pkg::word_t a, input mips_pkg::word_t b);
		return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // Signed compare
	endfunction

	function automatic mips_pkg::word_t next_fetch(input mips_pkg::word_t addr);
		return (addr == TAKEN_PC + 32'd8) ? TAKEN_TGT : addr + 32'd4;
	endfunction

	function automatic mips_pkg::word_t i_word(input logic [5:0] opc, input int rt, input int rs,
	                                           input logic [15:0] imm);
		return {opc, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic mips_pkg::word_t r_word(input logic [5:0] fn, input int rd, input int rs,
	                                           input int rt);
		return {mips_pkg::OPC_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic mips_pkg::word_t expect_of(input int r);
		return exp_val[5'(r)];
	endfunction

	task automatic put_word(input int idx, input mips_pkg::word_t word);
		prog[6'(idx)] = word;
	endtask

	task automatic place_addi(input int idx, input int rd, input logic [15:0] imm);
		put_word(idx, i_word(mips_pkg::OPC_ADDI, rd, 0, imm));
		exp_val[5'(rd)]   = sext(imm);
		may_write[5'(rd)] = 1'b1;
	endtask

	task automatic place_alu(input int idx, input logic [5:0] fn, input int rd, input int rs,
	                         input int rt, input mips_pkg::word_t value);
		put_word(idx, r_word(fn, rd, rs, rt));
		exp_val[5'(rd)]   = value;
		may_write[5'(rd)] = (rd != 0); // r0 never writes back
	endtask

	task automatic build_program();
		int          i;
		logic [15:0] mem_off;
		for (i = 0; i < PROG_WORDS; i++)
			prog[6'(i)] = '0;
		for (i = 0; i < mips_pkg::REG_COUNT; i++) begin
			exp_val[5'(i)]   = '0;
			may_write[5'(i)] = 1'b0;
		end
		place_addi(0, 1, 16'($urandom));
		place_addi(1, 2, 16'($urandom));
		place_addi(2, 3, 16'($urandom));
		// Operands one slot back come from memory, two slots back from writeback
		place_alu(3, mips_pkg::FN_ADD, 4, 2, 3, expect_of(2) + expect_of(3));
		place_alu(4, mips_pkg::FN_SUB, 5, 4, 1, expect_of(4) - expect_of(1));
		place_alu(5, mips_pkg::FN_AND, 6, 5, 2, expect_of(5) & expect_of(2));
		place_alu(6, mips_pkg::FN_OR, 7, 3, 5, expect_of(3) | expect_of(5));
		place_alu(7, mips_pkg::FN_SLT, 8, 6, 7, slt_val(expect_of(6), expect_of(7)));
		place_alu(8, mips_pkg::FN_SLT, 9, 7, 1, slt_val(expect_of(7), expect_of(1)));
		mem_off = 16'(($urandom % 256) * 4);
		put_word(9, i_word(mips_pkg::OPC_SW, 4, 0, mem_off));
		place_addi(10, 10, 16'($urandom));
		put_word(11, i_word(mips_pkg::OPC_LW, 11, 0, mem_off));
		exp_val[5'd11]   = expect_of(4);
		may_write[5'd11] = 1'b1;
		place_addi(12, 12, 16'($urandom)); // Gap before the load's first use
		place_alu(13, mips_pkg::FN_ADD, 13, 11, 12, expect_of(11) + expect_of(12));
		// Taken beq squashes slots 15 and 16
		put_word(TAKEN_IDX, i_word(mips_pkg::OPC_BEQ, 1, 1, 16'(BR_OFFSET)));
		put_word(15, i_word(mips_pkg::OPC_ADDI, 14, 0, 16'd1));
		put_word(16, i_word(mips_pkg::OPC_ADDI, 15, 0, 16'd1));
		place_addi(17, 16, 16'($urandom) | 16'h0001); // Nonzero so the next beq falls through
		put_word(18, i_word(mips_pkg::OPC_BEQ, 16, 0, 16'(BR_OFFSET)));
		place_addi(19, 17, 16'($urandom));
		place_addi(20, 18, 16'($urandom));
		place_alu(21, mips_pkg::FN_ADD, 0, 1, 2, '0);
		place_alu(22, mips_pkg::FN_ADD, 19, 0, 17, expect_of(17));
		place_alu(23, mips_pkg::FN_ADD, 20, 18, 0, expect_of(18));
	endtask

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	always @(posedge clk)
		if (wb_en)
			seen[wb_addr] <= 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cyc <= 0;
		else if (cyc < 1000)
			cyc <= cyc + 1;
	end

	first_fetch: assert property (@(posedge clk) $rose(arst_n) |-> imem_addr == mips_pkg::RESET_PC)
		else begin
			errors++;
			$display("mismatch at %0t: first fetch from %h", $time, $sampled(imem_addr));
		end

	fetch_step: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) |-> imem_addr == next_fetch($past(imem_addr)))
		else begin
			errors++;
			$display("mismatch at %0t: fetch from %h out of sequence", $time, $sampled(imem_addr));
		end

	wb_quiet: assert property (@(posedge clk) (!arst_n || cyc < 4) |-> !wb_en)
		else begin
			errors++;
			$display("wb_en was high at %0t before any instruction reached writeback", $time);
		end

	wb_allowed: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en |-> may_write[wb_addr] && !seen[wb_addr])
		else begin
			errors++;
			$display("register r%0d was written at %0t but no pending instruction targets it",
			         $sampled(wb_addr), $time);
		end

	wb_value: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en && may_write[wb_addr] |-> wb_data == exp_val[wb_addr])
		else begin
			errors++;
			$display("mismatch at %0t: r%0d got %h, expected %h", $time, $sampled(wb_addr),
			         $sampled(wb_data), exp_val[$sampled(wb_addr)]);
		end

	task automatic await_write(input int r, inout bit timed_out);
		int n;
		n = 0;
		while (!seen[5'(r)] && n < WAIT_LIMIT) begin
			@(posedge clk);
			#(DRIVE_DLY);
			n++;
		end
		if (!seen[5'(r)]) begin
			timed_out = 1'b1;
			$display("timeout: r%0d was not written within %0d cycles", r, WAIT_LIMIT);
		end
	endtask

	task automatic run_test(input string name, input int first, input int last);
		int errs_at_start;
		bit timed_out;
		int r;
		errs_at_start = errors;
		timed_out     = 1'b0;
		for (r = first; r <= last; r++) begin
			if (may_write[5'(r)]) // Squashed slots are skipped
				await_write(r, timed_out);
		end
		if (timed_out || errors != errs_at_start) begin
			failed++;
			$display("%0t test %s: failed", $time, name);
		end else begin
			passed++;
			$display("%0t test %s: passed", $time, name);
		end
	endtask

	initial begin
		arst_n = 1'b0;
		errors = 0;
		passed = 0;
		failed = 0;
		void'($urandom(SEED));
		build_program();
		repeat (10) @(posedge clk);
		#(DRIVE_DLY) arst_n = 1'b1;
		run_test("reset_fetch", 1, 1);
		run_test("addi", 2, 3);
		run_test("forwarding", 4, 9);
		run_test("load_store", 10, 13);
		run_test("branch", 14, 18);
		run_test("reg_zero", 19, 20);
		$display("tests passed: %0d, failed: %0d, check errors: %0d", passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk
);

	localparam int HALF_PERIOD = 4; // 8 ns period

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

`default_nettype wire
